/* compile.f */
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_status.sv
hw/uart_top.sv
tb/uart_tb_assert.sv
tb/uart_tb.sv

/* Makefile */
# Verilator flow for the UART testbench; the simulator exit status is the result

TOP := uart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP) -f compile.f
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* tb/uart_tb.sv */
/*
 * Testbench of uart_top at dl = 2, so one serial bit is OVERSAMPLE * 2 clocks.
 * Serial driver and monitor are 8N1 and sample the pad at the falling clock edge.
 */
`timescale 1ns/1ps

module uart_tb;

	localparam int DL      = 2;
	localparam int BIT_CYC = uart_pkg::OVERSAMPLE * DL;    // clocks per bit
	localparam int TIMEOUT = 12 * 10 * BIT_CYC + 2000;     // 12 chars of 10 bits, plus bus work

	logic clk = 1'b0;
	logic wb_rst_i;
	logic [uart_pkg::ADDR_W-1:0] wb_addr_i;
	logic [uart_pkg::DATA_W-1:0] wb_dat_i;
	logic [uart_pkg::DATA_W-1:0] wb_dat_o;
	logic wb_we_i;
	logic wb_re_i;
	logic srx_pad_i;
	logic stx_pad_o;
	logic rts_pad_o;
	logic dtr_pad_o;
	logic int_o;
	logic [31:0] rng = 32'hfb5a; // xorshift state
	int cycles = 0;

	uart_top uart_top_i (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.wb_addr_i (wb_addr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_we_i   (wb_we_i),
		.wb_re_i   (wb_re_i),
		.srx_pad_i (srx_pad_i),
		.stx_pad_o (stx_pad_o),
		.rts_pad_o (rts_pad_o),
		.dtr_pad_o (dtr_pad_o),
		.int_o     (int_o)
	);

	always #2 clk = ~clk; // 4 ns period

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: the test did not finish within %0d clock cycles", TIMEOUT);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		rng = xorshift32(rng);
		b   = rng[7:0];
	endtask

	task automatic report_mismatch(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		$display("FAIL t=%0t %s: got %02h, expected %02h", $time, what, got, exp);
		$display("TEST FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else report_mismatch(what, got, exp);
	endtask

	// write lands at the second edge
	task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
		@(posedge clk);
		wb_addr_i <= addr;
		wb_dat_i  <= data;
		wb_we_i   <= 1'b1;
		@(posedge clk);
		wb_we_i   <= 1'b0;
	endtask

	// read strobe for one cycle, data taken mid-cycle
	task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
		@(posedge clk);
		wb_addr_i <= addr;
		wb_re_i   <= 1'b1;
		@(negedge clk);
		data = wb_dat_o;
		@(posedge clk);
		wb_re_i   <= 1'b0;
	endtask

	// poll LSR until all mask bits are set
	task automatic wait_lsr(input logic [7:0] mask, output logic [7:0] lsr);
		lsr = 8'h00;
		while ((lsr & mask) != mask)
			bus_read(uart_pkg::REG_LS, lsr);
	endtask

	task automatic wait_int();
		@(negedge clk);
		while (int_o !== 1'b1)
			@(negedge clk);
	endtask

	// 8N1 frame on srx_pad_i, stop level selectable
	task automatic serial_send(input logic [7:0] b, input logic stop);
		int i;
		@(posedge clk);
		srx_pad_i <= 1'b0; // start bit
		repeat (BIT_CYC) @(posedge clk);
		for (i = 0; i < 8; i++)
		begin
			srx_pad_i <= b[i];
			repeat (BIT_CYC) @(posedge clk);
		end
		srx_pad_i <= stop;
		repeat (BIT_CYC) @(posedge clk);
		srx_pad_i <= 1'b1;
	endtask

	// decode one frame from stx_pad_o at mid-bit
	task automatic serial_receive(output logic [7:0] b, output logic stop);
		int i;
		@(negedge clk);
		while (stx_pad_o !== 1'b0)
			@(negedge clk);
		repeat (BIT_CYC / 2) @(negedge clk); // middle of start bit
		for (i = 0; i < 8; i++)
		begin
			repeat (BIT_CYC) @(negedge clk);
			b[i] = stx_pad_o;
		end
		repeat (BIT_CYC) @(negedge clk);
		stop = stx_pad_o;
	endtask

	initial
	begin
		logic [7:0] val;
		logic [7:0] exp;
		logic [7:0] exp2;
		logic stop_b;

		wb_rst_i  = 1'b1;
		wb_addr_i = '0;
		wb_dat_i  = '0;
		wb_we_i   = 1'b0;
		wb_re_i   = 1'b0;
		srx_pad_i = 1'b1;
		repeat (5) @(posedge clk);
		wb_rst_i <= 1'b0;

		// reset state
		@(negedge clk);
		check_byte("int_o after reset", {7'b0, int_o}, 8'h00);
		check_byte("rts_pad_o after reset", {7'b0, rts_pad_o}, 8'h01);
		check_byte("dtr_pad_o after reset", {7'b0, dtr_pad_o}, 8'h01);
		check_byte("stx_pad_o after reset", {7'b0, stx_pad_o}, 8'h01);
		bus_read(uart_pkg::REG_LC, val);
		check_byte("LCR after reset", val, 8'h03);
		bus_read(uart_pkg::REG_II, val);
		check_byte("IIR after reset", val, 8'hc1);
		bus_read(uart_pkg::REG_LS, val);
		check_byte("LSR after reset", val, 8'h60);

		// scratch, divisor latch, IER
		rand_byte(exp);
		bus_write(uart_pkg::REG_SR, exp);
		bus_read(uart_pkg::REG_SR, val);
		check_byte("scratch readback", val, exp);
		bus_write(uart_pkg::REG_LC, 8'h83); // DLAB on
		rand_byte(exp);
		bus_write(uart_pkg::REG_IE, exp);   // divisor high byte
		bus_read(uart_pkg::REG_IE, val);
		check_byte("divisor high readback", val, exp);
		bus_write(uart_pkg::REG_IE, 8'h00);
		bus_write(uart_pkg::REG_RB_TR, 8'(DL));
		bus_read(uart_pkg::REG_RB_TR, val);
		check_byte("divisor low readback", val, 8'(DL));
		bus_write(uart_pkg::REG_LC, 8'h03);
		rand_byte(exp);
		bus_write(uart_pkg::REG_IE, exp);
		bus_read(uart_pkg::REG_IE, val);
		check_byte("IER readback", val, exp & 8'h07); // three enable bits
		bus_write(uart_pkg::REG_IE, 8'h00);
		bus_write(uart_pkg::REG_MC, 8'h03); // rts and dtr on
		@(negedge clk);
		check_byte("rts_pad_o active", {7'b0, rts_pad_o}, 8'h00);
		check_byte("dtr_pad_o active", {7'b0, dtr_pad_o}, 8'h00);
		bus_write(uart_pkg::REG_MC, 8'h00);

		// transmit
		rand_byte(exp);
		bus_write(uart_pkg::REG_RB_TR, exp);
		serial_receive(val, stop_b);
		check_byte("transmitted byte", val, exp);
		check_byte("transmitted stop bit", {7'b0, stop_b}, 8'h01);
		wait_lsr(8'h20, val);
		wait_lsr(8'h40, val);
		check_byte("THRE and TEMT after transmit", val & 8'h60, 8'h60);

		// receive, then a frame with its stop bit low
		rand_byte(exp);
		serial_send(exp, 1'b1);
		wait_lsr(8'h01, val);
		bus_read(uart_pkg::REG_RB_TR, val);
		check_byte("received byte", val, exp);
		bus_read(uart_pkg::REG_LS, val);
		check_byte("DR after RB read", val & 8'h01, 8'h00);
		rand_byte(exp);
		serial_send(exp, 1'b0);
		wait_lsr(8'h01, val);
		check_byte("FE on low stop bit", val & 8'h08, 8'h08);
		bus_read(uart_pkg::REG_RB_TR, val);
		repeat (BIT_CYC * 2) @(posedge clk); // let the rx reject the false start

		// loopback with interrupts
		bus_write(uart_pkg::REG_MC, 8'h10);
		bus_write(uart_pkg::REG_IE, 8'h02); // THRE
		wait_int();
		bus_read(uart_pkg::REG_II, val);
		check_byte("IIR with THR empty", val, 8'hc2);
		bus_write(uart_pkg::REG_IE, 8'h03); // RDA and THRE
		rand_byte(exp);
		bus_write(uart_pkg::REG_RB_TR, exp);
		wait_lsr(8'h01, val);
		bus_read(uart_pkg::REG_II, val);
		check_byte("IIR after loopback reception", val, 8'hc4);
		bus_read(uart_pkg::REG_RB_TR, val);
		check_byte("loopback byte", val, exp);
		bus_write(uart_pkg::REG_IE, 8'h00);
		bus_write(uart_pkg::REG_MC, 8'h00);

		// overrun, no RB read between the frames
		bus_write(uart_pkg::REG_IE, 8'h04); // RLS
		rand_byte(exp);
		rand_byte(exp2);
		serial_send(exp, 1'b1);
		serial_send(exp2, 1'b1);
		@(negedge clk);
		check_byte("int_o on overrun", {7'b0, int_o}, 8'h01);
		bus_read(uart_pkg::REG_II, val);
		check_byte("IIR on overrun", val, 8'hc6);
		bus_read(uart_pkg::REG_LS, val);
		check_byte("LSR DR, OE, FE on overrun", val & 8'h0b, 8'h03);
		bus_read(uart_pkg::REG_LS, val);
		check_byte("OE and FE after LSR read", val & 8'h0a, 8'h00);
		bus_read(uart_pkg::REG_RB_TR, val);
		check_byte("newest byte after overrun", val, exp2);

		if (uart_top_i.u_assert.fail_cnt != 0)
		begin
			$display("the protocol checker reported %0d assertion failures",
				uart_top_i.u_assert.fail_cnt);
			$display("TEST FAIL");
			$fatal(1, "assertion failures");
		end
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

/* tb/uart_tb_assert.sv */
/*
 * Protocol checks bound into uart_top, observed at its bus and pad ports.
 * Failures raise $error and count in fail_cnt.
 */
`timescale 1ns/1ps

module uart_tb_assert (
	input logic                        clk,
	input logic                        wb_rst_i,
	input logic [uart_pkg::ADDR_W-1:0] addr_i,
	input logic [uart_pkg::DATA_W-1:0] wdat_i,  // bus write data
	input logic [uart_pkg::DATA_W-1:0] rdat_i,  // bus read data from the DUT
	input logic                        we_i,
	input logic                        re_i,
	input logic                        stx_pad_i, // DUT pad output
	input logic                        int_i
);

	int fail_cnt = 0; // read by the testbench at the end
	logic loop_q;     // MCR loop bit as last written on the bus
	logic ii_rd, ls_rd;

	assign ii_rd = re_i && (addr_i == uart_pkg::REG_II);
	assign ls_rd = re_i && (addr_i == uart_pkg::REG_LS);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			loop_q <= 1'b0;
		else if (we_i && addr_i == uart_pkg::REG_MC)
			loop_q <= wdat_i[uart_pkg::MCR_LOOP_BIT];
	end

	// pad idles high while tx is looped back
	a_loop_idle: assert property (@(posedge clk) disable iff (wb_rst_i)
		loop_q |-> stx_pad_i)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("stx_pad_o left the idle level during loopback");
	end

	// interrupt line only with a pending IIR code
	a_int_pending: assert property (@(posedge clk) disable iff (wb_rst_i)
		(int_i && ii_rd) |-> !rdat_i[0])
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("int_o high while IIR shows no pending interrupt");
	end

	// shifter empty needs holding register empty too
	a_temt_thre: assert property (@(posedge clk) disable iff (wb_rst_i)
		(ls_rd && rdat_i[uart_pkg::LS_TEMT]) |-> rdat_i[uart_pkg::LS_THRE])
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("LSR TEMT set while THRE is clear");
	end

endmodule

bind uart_top uart_tb_assert u_assert (
	.clk       (clk),
	.wb_rst_i  (wb_rst_i),
	.addr_i    (wb_addr_i),
	.wdat_i    (wb_dat_i),
	.rdat_i    (wb_dat_o),
	.we_i      (wb_we_i),
	.re_i      (wb_re_i),
	.stx_pad_i (stx_pad_o),
	.int_i     (int_o)
);

/* hw/uart_top.sv */
/*
 * 16550-style UART without FIFOs, 8N1 only. Register reads are combinational;
 * every bus access completes in the cycle it is presented.
 */
`timescale 1ns/1ps

module uart_top (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic [uart_pkg::ADDR_W-1:0] wb_addr_i,
	input  logic [uart_pkg::DATA_W-1:0] wb_dat_i,
	output logic [uart_pkg::DATA_W-1:0] wb_dat_o,
	input  logic                        wb_we_i,
	input  logic                        wb_re_i,
	input  logic                        srx_pad_i,
	output logic                        stx_pad_o,
	output logic                        rts_pad_o,
	output logic                        dtr_pad_o,
	output logic                        int_o
);

	logic [uart_pkg::DL_W-1:0]   dl;
	logic [uart_pkg::IE_RLS:0]   ier;
	logic [uart_pkg::DATA_W-1:0] lsr;
	logic [uart_pkg::DATA_W-1:0] iir;
	logic [uart_pkg::DATA_W-1:0] rx_data;
	logic loopback;
	logic thr_wr, rb_rd, lsr_rd, iir_rd;
	logic baud_en;
	logic txd, rxd;          // serial lines after loopback routing
	logic thr_empty, tx_idle;
	logic rx_done, rx_overrun, rx_frame_err;

	// loopback ties tx to rx internally, pad idles high
	assign rxd       = loopback ? txd : srx_pad_i;
	assign stx_pad_o = loopback ? 1'b1 : txd;

	uart_regs u_regs (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.wb_addr_i  (wb_addr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_we_i    (wb_we_i),
		.wb_re_i    (wb_re_i),
		.rx_data_i  (rx_data),
		.lsr_i      (lsr),
		.iir_i      (iir),
		.wb_dat_o   (wb_dat_o),
		.dl_o       (dl),
		.ier_o      (ier),
		.loopback_o (loopback),
		.rts_pad_o  (rts_pad_o),
		.dtr_pad_o  (dtr_pad_o),
		.thr_wr_o   (thr_wr),
		.rb_rd_o    (rb_rd),
		.lsr_rd_o   (lsr_rd),
		.iir_rd_o   (iir_rd)
	);

	uart_baud_gen u_baud (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.dl_i      (dl),
		.baud_en_o (baud_en)
	);

	uart_tx u_tx (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.baud_en_i   (baud_en),
		.thr_wr_i    (thr_wr),
		.wr_data_i   (wb_dat_i), // thr_wr is decoded in the write cycle itself
		.txd_o       (txd),
		.thr_empty_o (thr_empty),
		.tx_idle_o   (tx_idle)
	);

	uart_rx u_rx (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.baud_en_i      (baud_en),
		.rxd_i          (rxd),
		.rb_rd_i        (rb_rd),
		.rx_data_o      (rx_data),
		.rx_done_o      (rx_done),
		.rx_overrun_o   (rx_overrun),
		.rx_frame_err_o (rx_frame_err)
	);

	uart_status u_status (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.ier_i          (ier),
		.thr_empty_i    (thr_empty),
		.tx_idle_i      (tx_idle),
		.rx_done_i      (rx_done),
		.rx_overrun_i   (rx_overrun),
		.rx_frame_err_i (rx_frame_err),
		.rb_rd_i        (rb_rd),
		.lsr_rd_i       (lsr_rd),
		.iir_rd_i       (iir_rd),
		.thr_wr_i       (thr_wr),
		.lsr_o          (lsr),
		.iir_o          (iir),
		.int_o          (int_o)
	);

endmodule

/* hw/uart_status.sv */
/*
 * Line status and interrupt identification. IIR and int_o are registered
 * from the same priority encoder, so both lag the pending flags by one cycle.
 */
`timescale 1ns/1ps

module uart_status (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic [uart_pkg::IE_RLS:0]   ier_i,
	input  logic                        thr_empty_i,
	input  logic                        tx_idle_i,
	input  logic                        rx_done_i,
	input  logic                        rx_overrun_i,
	input  logic                        rx_frame_err_i,
	input  logic                        rb_rd_i,
	input  logic                        lsr_rd_i,
	input  logic                        iir_rd_i,
	input  logic                        thr_wr_i,
	output logic [uart_pkg::DATA_W-1:0] lsr_o,
	output logic [uart_pkg::DATA_W-1:0] iir_o,
	output logic                        int_o
);

	logic dr, oe, fe;
	logic rls_int, rda_int, thre_int;
	logic thre_int_d; // for rise detect
	logic thre_pnd;
	uart_pkg::iir_id_e iir_id, id_nxt;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			dr <= 1'b0;
			oe <= 1'b0;
			fe <= 1'b0;
		end
		else
		begin
			// new events win over a clearing read in the same cycle
			if (rx_done_i)
				dr <= 1'b1;
			else if (rb_rd_i)
				dr <= 1'b0;
			if (rx_done_i && rx_overrun_i)
				oe <= 1'b1;
			else if (lsr_rd_i)
				oe <= 1'b0;
			if (rx_done_i && rx_frame_err_i)
				fe <= 1'b1;
			else if (lsr_rd_i)
				fe <= 1'b0;
		end
	end

	always_comb
	begin
		lsr_o = '0;
		lsr_o[uart_pkg::LS_DR]   = dr;
		lsr_o[uart_pkg::LS_OE]   = oe;
		lsr_o[uart_pkg::LS_FE]   = fe;
		lsr_o[uart_pkg::LS_THRE] = thr_empty_i;
		lsr_o[uart_pkg::LS_TEMT] = thr_empty_i && tx_idle_i; // holding and shifter empty
	end

	assign rls_int  = ier_i[uart_pkg::IE_RLS] && (oe || fe);
	assign rda_int  = ier_i[uart_pkg::IE_RDA] && dr;
	assign thre_int = ier_i[uart_pkg::IE_THRE] && thr_empty_i;

	// THRE pending is edge set, cleared by a THR write or by reading its IIR code
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			thre_int_d <= 1'b0;
			thre_pnd   <= 1'b0;
		end
		else
		begin
			thre_int_d <= thre_int;
			if (thr_wr_i || (iir_rd_i && iir_id == uart_pkg::II_THRE))
				thre_pnd <= 1'b0;
			else if (thre_int && !thre_int_d)
				thre_pnd <= 1'b1;
			else
				thre_pnd <= thre_pnd && ier_i[uart_pkg::IE_THRE]; // drop if masked
		end
	end

	always_comb
	begin
		if (rls_int)
			id_nxt = uart_pkg::II_RLS;
		else if (rda_int)
			id_nxt = uart_pkg::II_RDA;
		else if (thre_pnd)
			id_nxt = uart_pkg::II_THRE;
		else
			id_nxt = uart_pkg::II_NONE;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			iir_id <= uart_pkg::II_NONE;
			int_o  <= 1'b0;
		end
		else
		begin
			iir_id <= id_nxt;
			int_o  <= (id_nxt != uart_pkg::II_NONE);
		end
	end

	assign iir_o = {uart_pkg::IIR_HI, iir_id};

endmodule

/* hw/uart_rx.sv */
/*
 * Receiver: 8N1 sampled at mid-bit, one-character buffer.
 * A character that completes while the buffer is full replaces it and flags overrun.
 */
`timescale 1ns/1ps

module uart_rx (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic                        baud_en_i,
	input  logic                        rxd_i,
	input  logic                        rb_rd_i,
	output logic [uart_pkg::DATA_W-1:0] rx_data_o,
	output logic                        rx_done_o,
	output logic                        rx_overrun_o,
	output logic                        rx_frame_err_o
);

	logic rxd_meta, rxd_s;               // synchronizer
	logic [uart_pkg::DATA_W-1:0] rsr;    // receive shift register
	logic rx_full;                       // buffer holds an unread character
	logic [uart_pkg::OS_W-1:0]  os_cnt;
	logic [uart_pkg::BIT_W-1:0] bit_cnt;
	uart_pkg::rx_state_e state;
	logic sample;
	logic stop_smp;

	assign sample   = baud_en_i && (os_cnt == uart_pkg::OS_LAST); // one bit after the last sample
	assign stop_smp = sample && (state == uart_pkg::RX_STOP);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd_i;
			rxd_s    <= rxd_meta;
		end
	end

	// data path, no reset
	always_ff @(posedge clk)
	begin
		if (sample && state == uart_pkg::RX_DATA)
			rsr <= {rxd_s, rsr[uart_pkg::DATA_W-1:1]}; // lsb arrives first
		if (stop_smp)
			rx_data_o <= rsr;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state          <= uart_pkg::RX_IDLE;
			os_cnt         <= '0;
			bit_cnt        <= '0;
			rx_full        <= 1'b0;
			rx_done_o      <= 1'b0;
			rx_overrun_o   <= 1'b0;
			rx_frame_err_o <= 1'b0;
		end
		else
		begin
			rx_done_o      <= stop_smp;
			rx_overrun_o   <= stop_smp && rx_full && !rb_rd_i;
			rx_frame_err_o <= stop_smp && !rxd_s; // stop bit low
			if (rb_rd_i)
				rx_full <= 1'b0;
			if (stop_smp)
				rx_full <= 1'b1;

			if (baud_en_i)
			begin
				case (state)
					uart_pkg::RX_IDLE:
						if (!rxd_s)
						begin
							state  <= uart_pkg::RX_START;
							os_cnt <= '0;
						end
					uart_pkg::RX_START:
						if (os_cnt == uart_pkg::OS_MID)
						begin
							// mid start bit, still low or a glitch
							state   <= rxd_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
							os_cnt  <= '0;
							bit_cnt <= '0;
						end
						else
							os_cnt <= os_cnt + 1'b1;
					uart_pkg::RX_DATA:
					begin
						os_cnt <= sample ? '0 : os_cnt + 1'b1;
						if (sample)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == uart_pkg::BIT_LAST)
								state <= uart_pkg::RX_STOP;
						end
					end
					default:
					begin
						os_cnt <= sample ? '0 : os_cnt + 1'b1;
						if (sample)
							state <= uart_pkg::RX_IDLE;
					end
				endcase
			end
		end
	end

endmodule

/* hw/uart_tx.sv */
/*
 * Transmitter: one holding register plus the shifter, 8N1, LSB first.
 * A write while the holding register is full overwrites the waiting character.
 */
`timescale 1ns/1ps

module uart_tx (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic                        baud_en_i,
	input  logic                        thr_wr_i,
	input  logic [uart_pkg::DATA_W-1:0] wr_data_i,
	output logic                        txd_o,
	output logic                        thr_empty_o,
	output logic                        tx_idle_o
);

	logic [uart_pkg::DATA_W-1:0] thr; // holding register
	logic [uart_pkg::DATA_W-1:0] tsr; // shift register
	logic thr_full;
	logic [uart_pkg::OS_W-1:0]  os_cnt;  // enables within a bit
	logic [uart_pkg::BIT_W-1:0] bit_cnt;
	uart_pkg::tx_state_e state;
	logic bit_end;
	logic load;

	assign bit_end = baud_en_i && (os_cnt == uart_pkg::OS_LAST);
	// take the next character when idle or straight after a stop bit
	assign load = thr_full && ((state == uart_pkg::TX_IDLE && baud_en_i) ||
		(state == uart_pkg::TX_STOP && bit_end));

	assign thr_empty_o = !thr_full;
	assign tx_idle_o   = (state == uart_pkg::TX_IDLE);

	always_ff @(posedge clk)
	begin
		if (thr_wr_i)
			thr <= wr_data_i;
		if (load)
			tsr <= thr;
		else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA))
			tsr <= tsr >> 1;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state    <= uart_pkg::TX_IDLE;
			thr_full <= 1'b0;
			os_cnt   <= '0;
			bit_cnt  <= '0;
			txd_o    <= 1'b1; // line idles high
		end
		else
		begin
			if (load)
				thr_full <= 1'b0;
			if (thr_wr_i)
				thr_full <= 1'b1; // a write in the load cycle wins
			if (baud_en_i)
				os_cnt <= bit_end ? '0 : os_cnt + 1'b1;

			if (load)
			begin
				state  <= uart_pkg::TX_START;
				txd_o  <= 1'b0; // start bit
				os_cnt <= '0;
			end
			else if (bit_end)
			begin
				case (state)
					uart_pkg::TX_START:
					begin
						txd_o   <= tsr[0];
						bit_cnt <= '0;
						state   <= uart_pkg::TX_DATA;
					end
					uart_pkg::TX_DATA:
						if (bit_cnt == uart_pkg::BIT_LAST)
						begin
							txd_o <= 1'b1; // stop bit
							state <= uart_pkg::TX_STOP;
						end
						else
						begin
							txd_o   <= tsr[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					uart_pkg::TX_STOP: state <= uart_pkg::TX_IDLE;
					default: ;
				endcase
			end
		end
	end

endmodule

/* hw/uart_regs.sv */
/*
 * Register file of the UART. Only DLAB in LCR has an effect; address 6 reads 0.
 * RB and LSR read side effects fire once per read strobe, on its first cycle.
 */
`timescale 1ns/1ps

module uart_regs (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic [uart_pkg::ADDR_W-1:0] wb_addr_i,
	input  logic [uart_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                        wb_we_i,
	input  logic                        wb_re_i,
	input  logic [uart_pkg::DATA_W-1:0] rx_data_i,
	input  logic [uart_pkg::DATA_W-1:0] lsr_i,
	input  logic [uart_pkg::DATA_W-1:0] iir_i,
	output logic [uart_pkg::DATA_W-1:0] wb_dat_o,
	output logic [uart_pkg::DL_W-1:0]   dl_o,
	output logic [uart_pkg::IE_RLS:0]   ier_o,
	output logic                        loopback_o,
	output logic                        rts_pad_o,
	output logic                        dtr_pad_o,
	output logic                        thr_wr_o,
	output logic                        rb_rd_o,
	output logic                        lsr_rd_o,
	output logic                        iir_rd_o
);

	logic [7:0] lcr;
	logic [uart_pkg::MCR_LOOP_BIT:0] mcr; // loop, out2, out1, rts, dtr
	logic [uart_pkg::DATA_W-1:0] scratch;
	logic dlab;
	logic rb_sel, ls_sel;     // read strobes at RB / LSR
	logic rb_sel_d, ls_sel_d; // previous cycle, for one-shot

	assign dlab = lcr[uart_pkg::LCR_DLAB_BIT];

	assign loopback_o = mcr[uart_pkg::MCR_LOOP_BIT];
	assign rts_pad_o  = ~mcr[uart_pkg::MCR_RTS_BIT]; // pads are active low
	assign dtr_pad_o  = ~mcr[uart_pkg::MCR_DTR_BIT];

	// access decode
	assign thr_wr_o = wb_we_i && !dlab && (wb_addr_i == uart_pkg::REG_RB_TR);
	assign rb_sel   = wb_re_i && !dlab && (wb_addr_i == uart_pkg::REG_RB_TR);
	assign ls_sel   = wb_re_i && (wb_addr_i == uart_pkg::REG_LS);
	assign iir_rd_o = wb_re_i && (wb_addr_i == uart_pkg::REG_II);
	assign rb_rd_o  = rb_sel && !rb_sel_d; // rise only
	assign lsr_rd_o = ls_sel && !ls_sel_d;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			rb_sel_d <= 1'b0;
			ls_sel_d <= 1'b0;
		end
		else
		begin
			rb_sel_d <= rb_sel;
			ls_sel_d <= ls_sel;
		end
	end

	// control register writes
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			lcr   <= uart_pkg::LCR_RESET; // 8n1
			dl_o  <= uart_pkg::DL_RESET;
			ier_o <= '0;                  // all interrupts off
			mcr   <= '0;
		end
		else if (wb_we_i)
		begin
			case (wb_addr_i)
				uart_pkg::REG_RB_TR: if (dlab) dl_o[uart_pkg::DATA_W-1:0] <= wb_dat_i;
				uart_pkg::REG_IE:
					if (dlab)
						dl_o[uart_pkg::DL_W-1:uart_pkg::DATA_W] <= wb_dat_i;
					else
						ier_o <= wb_dat_i[uart_pkg::IE_RLS:0];
				uart_pkg::REG_LC: lcr <= wb_dat_i;
				uart_pkg::REG_MC: mcr <= wb_dat_i[uart_pkg::MCR_LOOP_BIT:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wb_we_i && wb_addr_i == uart_pkg::REG_SR)
			scratch <= wb_dat_i;
	end

	// read mux, combinational
	always_comb
	begin
		case (wb_addr_i)
			uart_pkg::REG_RB_TR: wb_dat_o = dlab ? dl_o[uart_pkg::DATA_W-1:0] : rx_data_i;
			uart_pkg::REG_IE:
				wb_dat_o = dlab ? dl_o[uart_pkg::DL_W-1:uart_pkg::DATA_W] : {5'b0, ier_o};
			uart_pkg::REG_II: wb_dat_o = iir_i;
			uart_pkg::REG_LC: wb_dat_o = lcr;
			uart_pkg::REG_MC: wb_dat_o = {3'b0, mcr};
			uart_pkg::REG_LS: wb_dat_o = lsr_i;
			uart_pkg::REG_SR: wb_dat_o = scratch;
			default:          wb_dat_o = '0; // no MSR
		endcase
	end

endmodule

/* hw/uart_baud_gen.sv */
/*
 * 16x oversampling enable, one pulse every dl cycles; silent while dl is 0.
 * A divisor change restarts the count.
 */
`timescale 1ns/1ps

module uart_baud_gen (
	input  logic                      clk,
	input  logic                      wb_rst_i,
	input  logic [uart_pkg::DL_W-1:0] dl_i,
	output logic                      baud_en_o
);

	logic [uart_pkg::DL_W-1:0] cnt;
	logic [uart_pkg::DL_W-1:0] dl_q; // last divisor seen
	logic dl_chg;

	assign dl_chg    = (dl_i != dl_q);
	assign baud_en_o = (|dl_i) && (cnt == '0) && !dl_chg;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			cnt  <= '0;
			dl_q <= uart_pkg::DL_RESET;
		end
		else
		begin
			dl_q <= dl_i;
			if (dl_chg || cnt == '0)
				cnt <= dl_i - 1'b1; // preset
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

/* hw/uart_pkg.sv */
/*
 * Shared constants of the UART: 8 data bits, 1 stop bit, no parity.
 * OVERSAMPLE must be a power of two.
 */
package uart_pkg;

	localparam int ADDR_W     = 3;  // byte register bus
	localparam int DATA_W     = 8;  // character width
	localparam int DL_W       = 16; // divisor latch
	localparam int OVERSAMPLE = 16; // baud enables per bit

	localparam int OS_W  = $clog2(OVERSAMPLE);
	localparam int BIT_W = $clog2(DATA_W);
	localparam logic [OS_W-1:0] OS_LAST   = OS_W'(OVERSAMPLE - 1);
	localparam logic [OS_W-1:0] OS_MID    = OS_W'(OVERSAMPLE / 2 - 1); // detect to mid-bit, less one
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_W - 1);

	localparam logic [7:0] LCR_RESET    = 8'h03;
	localparam logic [DL_W-1:0] DL_RESET = 16'h0012;
	localparam logic [3:0] IIR_HI       = 4'b1100; // upper IIR nibble

	localparam int LCR_DLAB_BIT = 7;
	localparam int MCR_LOOP_BIT = 4;
	localparam int MCR_RTS_BIT  = 1;
	localparam int MCR_DTR_BIT  = 0;

	// line status bits
	localparam int LS_DR   = 0;
	localparam int LS_OE   = 1;
	localparam int LS_FE   = 3;
	localparam int LS_THRE = 5;
	localparam int LS_TEMT = 6;

	// interrupt enable bits
	localparam int IE_RDA  = 0;
	localparam int IE_THRE = 1;
	localparam int IE_RLS  = 2;

	typedef enum logic [2:0] {
		REG_RB_TR = 3'd0, // rx buffer on read, tx holding on write
		REG_IE    = 3'd1,
		REG_II    = 3'd2,
		REG_LC    = 3'd3,
		REG_MC    = 3'd4,
		REG_LS    = 3'd5,
		REG_SR    = 3'd7
	} uart_reg_e;

	typedef enum logic [3:0] {
		II_NONE = 4'h1,
		II_THRE = 4'h2,
		II_RDA  = 4'h4,
		II_RLS  = 4'h6
	} iir_id_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage
